// File: hw/alu.sv
`timescale 1ns/10ps

module alu
    import mips_pkg::*;
(
    input  instr_word_t instr,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic [31:0] result,
    output logic [4:0]  dest,
    output logic        wr_en
);

    alu_op_e     op;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {16'd0, instr.i.imm};

    // ************************************************************
    // decode
    // ************************************************************
    always_comb begin
        op    = ALU_NONE;
        opa   = rs_data;
        opb   = imm_sext;
        dest  = instr.i.rt;
        wr_en = 1'b0;
        case (instr.r.opcode)
            OP_SPECIAL: begin
                dest  = instr.r.rd;
                opb   = rt_data;
                wr_en = 1'b1;
                case (instr.r.funct)
                    F_ADDU: op = ALU_ADD;
                    F_SUBU: op = ALU_SUB;
                    F_AND:  op = ALU_AND;
                    F_OR:   op = ALU_OR;
                    F_SLT:  op = ALU_SLT;
                    F_SLL: begin
                        // shift works on rt, amount from shamt.
                        op  = ALU_SLL;
                        opa = rt_data;
                        opb = {27'd0, instr.r.shamt};
                    end
                    default: wr_en = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                op    = ALU_ADD;
                wr_en = 1'b1;
            end
            OP_ANDI: begin
                op    = ALU_AND;
                opb   = imm_zext;
                wr_en = 1'b1;
            end
            OP_ORI: begin
                op    = ALU_OR;
                opb   = imm_zext;
                wr_en = 1'b1;
            end
            OP_LUI: begin
                op    = ALU_LUI;
                wr_en = 1'b1;
            end
            // address sum only, the core writes lw data after MEM.
            OP_LW, OP_SW: op = ALU_ADD;
            default: op = ALU_NONE;
        endcase
    end

    // ************************************************************
    // datapath
    // ************************************************************
    always_comb begin
        case (op)
            ALU_ADD: result = opa + opb;
            ALU_SUB: result = opa - opb;
            ALU_AND: result = opa & opb;
            ALU_OR:  result = opa | opb;
            ALU_SLT: result = {31'd0, $signed(opa) < $signed(opb)};
            ALU_SLL: result = opa << opb[4:0];
            ALU_LUI: result = {opb[15:0], 16'd0};
            default: result = 32'd0;
        endcase
    end

endmodule

// File: hw/avalon_if.sv
`timescale 1ns/10ps

interface avalon_if (
    input logic clk
);
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        waitrequest;
    logic [31:0] readdata;

    // master keeps everything steady while waitrequest is high.
    modport master (
        input  clk,
        input  waitrequest,
        input  readdata,
        output address,
        output read,
        output write,
        output writedata,
        output byteenable
    );

    modport slave (
        input  clk,
        input  address,
        input  read,
        input  write,
        input  writedata,
        input  byteenable,
        output waitrequest,
        output readdata
    );

endinterface

// File: hw/avalon_ram.sv
`timescale 1ns/10ps

module avalon_ram
    import mips_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    avalon_if.slave           bus,
    input  logic              load_en,
    input  logic [MEM_AW-1:0] load_addr,
    input  logic [31:0]       load_data
);

    logic [31:0]       mem [MEM_WORDS];
    logic [MEM_AW-1:0] word_addr;
    logic              access;
    logic              second;

    // byte address to word index.
    assign word_addr = bus.address[MEM_AW+1:2];
    assign access    = bus.read | bus.write;

    // ************************************************************
    // one wait cycle per access
    // ************************************************************
    // first cycle stalls, second cycle completes.
    assign bus.waitrequest = access & ~second;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            second <= 1'b0;
        end else begin
            second <= access & ~second;
        end
    end

    // ************************************************************
    // storage
    // ************************************************************
    always_ff @(posedge clk) begin
        // read is captured in the wait cycle, valid when it completes.
        if (bus.read && !second) begin
            bus.readdata <= mem[word_addr];
        end
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (bus.write && second) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.byteenable[b]) begin
                    mem[word_addr][8*b +: 8] <= bus.writedata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/10ps

module branch_unit
    import mips_pkg::*;
(
    input  instr_word_t instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic        is_jump,
    output logic [31:0] target
);

    logic [31:0] pc_plus4;
    logic [31:0] br_offset;
    logic        equal;

    assign pc_plus4  = pc + 32'd4;
    assign br_offset = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign equal     = (rs_data == rt_data);

    always_comb begin
        is_jump = 1'b0;
        target  = pc_plus4 + br_offset;
        case (instr.i.opcode)
            OP_BEQ: is_jump = equal;
            OP_BNE: is_jump = !equal;
            OP_J: begin
                // pseudo-direct, top nibble from the delay slot address.
                is_jump = 1'b1;
                target  = {pc_plus4[31:28], instr.raw[25:0], 2'b00};
            end
            OP_SPECIAL: begin
                if (instr.r.funct == F_JR) begin
                    is_jump = 1'b1;
                    target  = rs_data;
                end
            end
            default: is_jump = 1'b0;
        endcase
    end

endmodule

// File: hw/cpu_core.sv
`timescale 1ns/10ps

module cpu_core
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        run,
    output logic        active,
    output logic [31:0] register_v0,
    avalon_if.master    bus
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    state_e      state;
    logic [31:0] pc;
    instr_word_t ir;
    logic        pend_valid;
    logic [31:0] pend_target;
    logic [31:0] next_pc;
    logic        is_mem;

    // operands latched for the MEM state.
    logic [31:0] mem_addr;
    logic [31:0] store_data;
    logic [4:0]  load_dest;
    logic        mem_is_load;
    logic        mem_done;

    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        rf_wr_en;
    logic [4:0]  rf_wr_addr;
    logic [31:0] rf_wr_data;
    logic [31:0] alu_result;
    logic [4:0]  alu_dest;
    logic        alu_wr_en;
    logic        br_jump;
    logic [31:0] br_target;

    reg_file u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (ir.r.rs),
        .rt_addr (ir.r.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (rf_wr_en),
        .wr_addr (rf_wr_addr),
        .wr_data (rf_wr_data),
        .v0      (register_v0)
    );

    alu u_alu (
        .instr   (ir),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .result  (alu_result),
        .dest    (alu_dest),
        .wr_en   (alu_wr_en)
    );

    branch_unit u_branch (
        .instr   (ir),
        .pc      (pc),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .is_jump (br_jump),
        .target  (br_target)
    );

    // a pending target is taken right after the delay slot.
    assign next_pc  = pend_valid ? pend_target : pc + 32'd4;
    assign is_mem   = (ir.i.opcode == OP_LW) || (ir.i.opcode == OP_SW);
    assign mem_done = (state == S_MEM) && !bus.waitrequest;

    // ************************************************************
    // avalon master outputs
    // ************************************************************
    assign bus.address    = (state == S_MEM) ? mem_addr : pc;
    assign bus.read       = (state == S_FETCH) || (state == S_MEM && mem_is_load);
    assign bus.write      = (state == S_MEM) && !mem_is_load;
    assign bus.writedata  = store_data;
    assign bus.byteenable = 4'hf;

    // write-back in EXEC, or lw data at the end of MEM.
    always_comb begin
        rf_wr_en   = (state == S_EXEC) && alu_wr_en;
        rf_wr_addr = alu_dest;
        rf_wr_data = alu_result;
        if (mem_done && mem_is_load) begin
            rf_wr_en   = 1'b1;
            rf_wr_addr = load_dest;
            rf_wr_data = bus.readdata;
        end
    end

    // ************************************************************
    // control FSM
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            active     <= 1'b0;
            pc         <= 32'd0;
            pend_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (run) begin
                        pc         <= RESET_PC;
                        pend_valid <= 1'b0;
                        active     <= 1'b1;
                        state      <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (!bus.waitrequest) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    pc         <= next_pc;
                    pend_valid <= br_jump;
                    if (is_mem) begin
                        state <= S_MEM;
                    end else if (next_pc == HALT_PC) begin
                        state <= S_HALT;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_MEM: begin
                    if (!bus.waitrequest) begin
                        state <= (pc == HALT_PC) ? S_HALT : S_FETCH;
                    end
                end
                default: begin
                    active <= 1'b0;
                    state  <= S_IDLE;
                end
            endcase
        end
    end

    // instruction and memory operands.
    always_ff @(posedge clk) begin
        if (state == S_FETCH && !bus.waitrequest) begin
            ir <= bus.readdata;
        end
        if (state == S_EXEC) begin
            pend_target <= br_target;
            mem_addr    <= alu_result;
            store_data  <= rt_data;
            load_dest   <= alu_dest;
            mem_is_load <= (ir.i.opcode == OP_LW);
        end
    end

endmodule

// File: hw/mips_pkg.sv
package mips_pkg;

    // ************************************************************
    // address and sizing constants
    // ************************************************************
    localparam logic [31:0] RESET_PC  = 32'h0000_0004;
    localparam logic [31:0] HALT_PC   = 32'h0000_0000;
    localparam int          MEM_WORDS = 256;
    localparam int          MEM_AW    = $clog2(MEM_WORDS);
    localparam logic [4:0]  REG_V0    = 5'd2;

    // ************************************************************
    // instruction encodings
    // ************************************************************
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a
    } funct_e;

    // operations the alu actually performs after decode.
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_NONE
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_type_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    // j-type target comes from raw[25:0].
    typedef union packed {
        logic [31:0] raw;
        r_type_t     r;
        i_type_t     i;
    } instr_word_t;

endpackage

// File: hw/mips_system.sv
`timescale 1ns/10ps

module mips_system
    import mips_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              run,
    output logic              active,
    output logic [31:0]       register_v0,
    input  logic              load_en,
    input  logic [MEM_AW-1:0] load_addr,
    input  logic [31:0]       load_data
);

    // processor to memory bus.
    avalon_if bus (
        .clk (clk)
    );

    cpu_core u_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .active      (active),
        .register_v0 (register_v0),
        .bus         (bus.master)
    );

    // program is preloaded here while the core is idle.
    avalon_ram u_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (bus.slave),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: hw/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] v0
);

    // register 0 has no storage.
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, zero for $0.
    always_comb begin
        rs_data = 32'd0;
        rt_data = 32'd0;
        if (rs_addr != 5'd0) begin
            rs_data = regs[rs_addr];
        end
        if (rt_addr != 5'd0) begin
            rt_data = regs[rt_addr];
        end
    end

    assign v0 = regs[REG_V0];

endmodule

// File: mips_system.f
hw/mips_pkg.sv
hw/avalon_if.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/cpu_core.sv
hw/avalon_ram.sv
hw/mips_system.sv
test/mips_system_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mips_system testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mips_system_tb --Mdir "$build_dir" -o mips_system_sim \
    -f mips_system.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/mips_system_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" "$log_file"; then
    exit 1
fi
exit 0

// File: test/mips_system_tb.sv
`timescale 1ns/10ps

module mips_system_tb
    import mips_pkg::*;
();

    localparam int START_TIMEOUT = 8;
    localparam int RUN_TIMEOUT   = 20000;
    localparam int MODEL_STEPS   = 4000;

    logic              clk;
    logic              arst_n;
    logic              run;
    logic              active;
    logic [31:0]       register_v0;
    logic              load_en;
    logic [MEM_AW-1:0] load_addr;
    logic [31:0]       load_data;

    // program words from RESET_PC on, plus single data words.
    logic [31:0] prog [$];
    int          preset_idx [$];
    logic [31:0] preset_val [$];
    logic [31:0] image [MEM_WORDS];
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_v0;
    logic        timed_out;
    int          check_count;
    int          error_count;
    int          timeout_count;

    mips_system uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .active      (active),
        .register_v0 (register_v0),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ************************************************************
    // instruction encoding
    // ************************************************************
    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] shamt,
                                             input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encode_j(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    // every byte of the word follows the word address.
    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a ^ 8'h5a, ~a, a, a ^ 8'hc3};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (timed_out) begin
            return;
        end
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("ERROR at %0d ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    // ************************************************************
    // reference instruction model
    // ************************************************************
    task automatic model_write(input logic [4:0] dst, input logic [31:0] val);
        if (dst != 5'd0) begin
            model_regs[dst] = val;
        end
    endtask

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] pend;
        logic        pend_valid;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] addr;
        logic [31:0] tgt;
        logic        take;
        int          steps;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = image[i];
        end
        pc = RESET_PC;
        pend = 32'd0;
        pend_valid = 1'b0;
        steps = 0;
        do begin
            w = model_mem[pc[MEM_AW+1:2]];
            a = model_regs[w[25:21]];
            b = model_regs[w[20:16]];
            sx = {{16{w[15]}}, w[15:0]};
            zx = {16'h0000, w[15:0]};
            addr = a + sx;
            take = 1'b0;
            tgt = pc + 32'd4 + (sx << 2);
            case (w[31:26])
                OP_SPECIAL: begin
                    case (w[5:0])
                        F_ADDU: model_write(w[15:11], a + b);
                        F_SUBU: model_write(w[15:11], a - b);
                        F_AND:  model_write(w[15:11], a & b);
                        F_OR:   model_write(w[15:11], a | b);
                        F_SLT:  model_write(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        F_SLL:  model_write(w[15:11], b << w[10:6]);
                        F_JR: begin
                            take = 1'b1;
                            tgt = a;
                        end
                        default: take = 1'b0;
                    endcase
                end
                OP_ADDIU: model_write(w[20:16], a + sx);
                OP_ANDI:  model_write(w[20:16], a & zx);
                OP_ORI:   model_write(w[20:16], a | zx);
                OP_LUI:   model_write(w[20:16], {w[15:0], 16'h0000});
                OP_LW:    model_write(w[20:16], model_mem[addr[MEM_AW+1:2]]);
                OP_SW:    model_mem[addr[MEM_AW+1:2]] = b;
                OP_BEQ:   take = (a == b);
                OP_BNE:   take = (a != b);
                OP_J: begin
                    take = 1'b1;
                    tgt = pc + 32'd4;
                    tgt = {tgt[31:28], w[25:0], 2'b00};
                end
                default: take = 1'b0;
            endcase
            // the delay slot runs before a pending target is taken.
            pc = pend_valid ? pend : pc + 32'd4;
            pend_valid = take;
            pend = tgt;
            steps++;
        end while (pc != HALT_PC && steps < MODEL_STEPS);
        assert (pc == HALT_PC) else begin
            error_count++;
            $display("reference model did not reach address 0 within %0d steps", MODEL_STEPS);
        end
        model_v0 = model_regs[REG_V0];
    endtask

    // ************************************************************
    // program load and run
    // ************************************************************
    task automatic new_program();
        prog.delete();
        preset_idx.delete();
        preset_val.delete();
    endtask

    // jr $0 with a nop in its delay slot.
    task automatic finish_program();
        prog.push_back(encode_r(5'd0, 5'd0, 5'd0, 5'd0, F_JR));
        prog.push_back(encode_r(5'd0, 5'd0, 5'd0, 5'd0, F_SLL));
    endtask

    task automatic run_program(input string name);
        int cycles;
        int base;
        if (timed_out) begin
            return;
        end
        base = int'(RESET_PC >> 2);
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = fill_word(i);
        end
        foreach (prog[k]) begin
            image[base + k] = prog[k];
        end
        foreach (preset_idx[k]) begin
            image[preset_idx[k]] = preset_val[k];
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(negedge clk);
            load_en = 1'b1;
            load_addr = i[MEM_AW-1:0];
            load_data = image[i];
        end
        @(negedge clk);
        load_en = 1'b0;
        run_model();
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
        cycles = 0;
        while (!active && cycles < START_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (active) else begin
            timeout_count++;
            timed_out = 1'b1;
            $display("%0d ns: active did not rise after run in %s", $time, name);
        end
        if (timed_out) begin
            return;
        end
        cycles = 0;
        while (active && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (!active) else begin
            timeout_count++;
            timed_out = 1'b1;
            $display("%0d ns: program %s did not halt within %0d cycles", $time, name,
                     RUN_TIMEOUT);
        end
        check_value("register_v0", register_v0, model_v0);
        check_value("read", {31'd0, uut.bus.read}, 32'd0);
        check_value("write", {31'd0, uut.bus.write}, 32'd0);
    endtask

    // ************************************************************
    // program builders
    // ************************************************************
    task automatic alu_program();
        int          n;
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        new_program();
        n = 8 + int'($urandom % 8);
        for (int k = 0; k < n; k++) begin
            rs = 5'($urandom % 8);
            rt = 5'($urandom % 8);
            rd = 5'(2 + $urandom % 6);
            sh = 5'($urandom);
            imm = 16'($urandom);
            kind = int'($urandom % 10);
            case (kind)
                0: prog.push_back(encode_i(OP_ADDIU, rs, rd, imm));
                1: prog.push_back(encode_i(OP_ANDI, rs, rd, imm));
                2: prog.push_back(encode_i(OP_ORI, rs, rd, imm));
                3: prog.push_back(encode_i(OP_LUI, 5'd0, rd, imm));
                4: prog.push_back(encode_r(rs, rt, rd, 5'd0, F_ADDU));
                5: prog.push_back(encode_r(rs, rt, rd, 5'd0, F_SUBU));
                6: prog.push_back(encode_r(rs, rt, rd, 5'd0, F_AND));
                7: prog.push_back(encode_r(rs, rt, rd, 5'd0, F_OR));
                8: prog.push_back(encode_r(rs, rt, rd, 5'd0, F_SLT));
                default: prog.push_back(encode_r(5'd0, rt, rd, sh, F_SLL));
            endcase
        end
        // fold two registers into v0 at the end.
        prog.push_back(encode_r(5'($urandom % 8), 5'($urandom % 8), REG_V0, 5'd0, F_ADDU));
        finish_program();
        run_program("alu mix");
    endtask

    task automatic store_then_load();
        int          idx;
        logic [31:0] val;
        idx = 64 + int'($urandom % 192);
        val = $urandom;
        new_program();
        prog.push_back(encode_i(OP_LUI, 5'd0, 5'd3, val[31:16]));
        prog.push_back(encode_i(OP_ORI, 5'd3, 5'd3, val[15:0]));
        prog.push_back(encode_i(OP_ADDIU, 5'd0, 5'd4, 16'(idx * 4 - 8)));
        prog.push_back(encode_i(OP_SW, 5'd4, 5'd3, 16'd8));
        prog.push_back(encode_i(OP_ADDIU, 5'd0, REG_V0, 16'h1234));
        prog.push_back(encode_i(OP_LW, 5'd4, REG_V0, 16'd8));
        finish_program();
        run_program("store then load");
        check_value("register_v0", register_v0, val);
    endtask

    task automatic load_preloaded();
        int          idx;
        logic [31:0] val;
        idx = 64 + int'($urandom % 192);
        val = $urandom;
        new_program();
        preset_idx.push_back(idx);
        preset_val.push_back(val);
        prog.push_back(encode_i(OP_LW, 5'd0, REG_V0, 16'(idx * 4)));
        finish_program();
        run_program("load preloaded word");
        check_value("register_v0", register_v0, val);
    endtask

    // the transfer sits at 0x0c and skips the word at 0x14 when taken.
    task automatic branch_program(input logic [5:0] op, input logic equal_ops);
        logic [15:0] a;
        logic [15:0] b;
        logic [7:0]  k1;
        logic [7:0]  k2;
        logic [7:0]  k3;
        logic        taken;
        logic [31:0] expected;
        a = 16'($urandom) & 16'h7fff;
        b = equal_ops ? a : a + 16'd1;
        k1 = 8'($urandom);
        k2 = 8'($urandom);
        k3 = 8'($urandom);
        taken = (op == OP_J) || ((op == OP_BEQ) == equal_ops);
        new_program();
        prog.push_back(encode_i(OP_ADDIU, 5'd0, 5'd3, a));
        prog.push_back(encode_i(OP_ADDIU, 5'd0, 5'd4, b));
        if (op == OP_J) begin
            prog.push_back(encode_j(OP_J, 26'h000_0006));
        end else begin
            prog.push_back(encode_i(op, 5'd3, 5'd4, 16'd2));
        end
        prog.push_back(encode_i(OP_ADDIU, 5'd0, REG_V0, {8'h00, k1}));
        prog.push_back(encode_i(OP_ADDIU, REG_V0, REG_V0, {8'h00, k2}));
        prog.push_back(encode_i(OP_ADDIU, REG_V0, REG_V0, {8'h00, k3}));
        finish_program();
        expected = {24'd0, k1} + {24'd0, k3};
        if (!taken) begin
            expected = expected + {24'd0, k2};
        end
        run_program($sformatf("transfer op 0x%02h equal %0b", op, equal_ops));
        check_value("register_v0", register_v0, expected);
    endtask

    // backward bne, v0 keeps its value from the previous run.
    task automatic countdown_loop();
        logic [15:0] n;
        logic [15:0] k;
        n = 16'(1 + $urandom % 8);
        k = 16'($urandom % 256);
        new_program();
        prog.push_back(encode_i(OP_ADDIU, 5'd0, 5'd3, n));
        prog.push_back(encode_i(OP_ADDIU, REG_V0, REG_V0, k));
        prog.push_back(encode_i(OP_ADDIU, 5'd3, 5'd3, 16'hffff));
        prog.push_back(encode_i(OP_BNE, 5'd3, 5'd0, 16'hfffd));
        prog.push_back(encode_r(5'd0, 5'd0, 5'd0, 5'd0, F_SLL));
        finish_program();
        run_program("countdown loop");
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************
    initial begin
        void'($urandom(32'h6148_dbce));
        arst_n = 1'b0;
        run = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = 32'd0;
        timed_out = 1'b0;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("active", {31'd0, active}, 32'd0);
        check_value("register_v0", register_v0, 32'd0);
        check_value("read", {31'd0, uut.bus.read}, 32'd0);
        check_value("write", {31'd0, uut.bus.write}, 32'd0);

        // jr $0 with addiu in the delay slot, the word after it never runs.
        new_program();
        prog.push_back(encode_r(5'd0, 5'd0, 5'd0, 5'd0, F_JR));
        prog.push_back(encode_i(OP_ADDIU, 5'd0, REG_V0, 16'h0010));
        prog.push_back(encode_i(OP_ADDIU, 5'd0, REG_V0, 16'h0020));
        run_program("delay slot");
        check_value("register_v0", register_v0, 32'h0000_0010);

        for (int t = 0; t < 12; t++) begin
            alu_program();
        end
        for (int t = 0; t < 6; t++) begin
            store_then_load();
        end
        for (int t = 0; t < 4; t++) begin
            load_preloaded();
        end
        for (int t = 0; t < 2; t++) begin
            branch_program(OP_BEQ, 1'b1);
            branch_program(OP_BEQ, 1'b0);
            branch_program(OP_BNE, 1'b1);
            branch_program(OP_BNE, 1'b0);
            branch_program(OP_J, 1'b0);
        end
        for (int t = 0; t < 3; t++) begin
            countdown_loop();
        end

        $display("checks %0d, value errors %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
